//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - design/mem_bus_pkg.sv
      - design/mem_map_pkg.sv
      - design/mem_req_if.sv
      - design/page_map.sv
      - design/bus_sequencer.sv
      - design/mem_module.sv
      - design/read_collector.sv
      - design/mem_subsystem.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_mem_subsystem.sv

//--- build.f
design/mem_bus_pkg.sv
design/mem_map_pkg.sv
design/mem_req_if.sv
design/page_map.sv
design/bus_sequencer.sv
design/mem_module.sv
design/read_collector.sv
design/mem_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_mem_subsystem.sv

//--- design/bus_sequencer.sv
`timescale 1ns/1ns

module bus_sequencer (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  rd,
	input  logic                                  wr,
	input  logic                                  cfg,
	input  logic [mem_bus_pkg::SEG_W-1:0]         seg,
	input  logic [mem_bus_pkg::ADDR_W-1:0]        addr,
	input  logic [mem_bus_pkg::DATA_W-1:0]        wdata,
	output logic                                  lookup_en,
	output logic [mem_map_pkg::PAGE_W-1:0]        page,
	output logic                                  cfg_we,
	output logic [mem_map_pkg::PAGE_W-1:0]        cfg_page,
	output mem_map_pkg::map_entry_t               cfg_entry,
	input  mem_map_pkg::map_entry_t               entry,
	mem_req_if.master                             req_if,
	output logic [mem_map_pkg::NUM_MODULES-1:0]   sel,
	input  logic                                  done,
	output logic                                  ok
);

	mem_bus_pkg::seq_state_e state;
	mem_bus_pkg::bus_op_e    op;
	mem_bus_pkg::bus_op_e    next_op;

	logic any_strobe;
	logic armed; // set once all strobes have been seen low.
	logic start;

	assign any_strobe = rd | wr | cfg;
	assign start      = (state == mem_bus_pkg::S_IDLE) & any_strobe & armed;

	// only one strobe is expected, read wins if the master breaks that rule.
	assign next_op = rd ? mem_bus_pkg::OP_READ :
	                 wr ? mem_bus_pkg::OP_WRITE : mem_bus_pkg::OP_CFG;

	// ====================
	// handshake FSM
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= mem_bus_pkg::S_IDLE;
			op        <= mem_bus_pkg::OP_NONE;
			armed     <= 1'b1;
			lookup_en <= 1'b0;
			cfg_we    <= 1'b0;
			req_if.req <= 1'b0;
			sel       <= '0;
			ok        <= 1'b0;
		end else begin
			// lookup, map write and module request are single cycle pulses.
			lookup_en  <= 1'b0;
			cfg_we     <= 1'b0;
			req_if.req <= 1'b0;
			sel        <= '0;

			case (state)
				mem_bus_pkg::S_IDLE: begin
					if (!any_strobe) begin
						armed <= 1'b1;
					end else if (start) begin
						armed     <= 1'b0;
						op        <= next_op;
						lookup_en <= (next_op != mem_bus_pkg::OP_CFG);
						cfg_we    <= (next_op == mem_bus_pkg::OP_CFG);
						state     <= mem_bus_pkg::S_MAP;
					end
				end

				mem_bus_pkg::S_MAP: begin
					// the map is written or the entry is registered on this edge.
					if (op == mem_bus_pkg::OP_CFG)
						state <= mem_bus_pkg::S_WAIT;
					else
						state <= mem_bus_pkg::S_ACCESS;
				end

				mem_bus_pkg::S_ACCESS: begin
					if (entry.valid) begin
						req_if.req <= 1'b1;
						sel        <= mem_map_pkg::NUM_MODULES'(1) << entry.mod_id;
						state      <= mem_bus_pkg::S_WAIT;
					end else begin
						// unmapped page, no ok and the master times out.
						op    <= mem_bus_pkg::OP_NONE;
						state <= mem_bus_pkg::S_IDLE;
					end
				end

				mem_bus_pkg::S_WAIT: begin
					// writes and configures are finished here, reads wait for the collector.
					if (op != mem_bus_pkg::OP_READ || done) begin
						ok    <= 1'b1;
						state <= mem_bus_pkg::S_OK;
					end
				end

				mem_bus_pkg::S_OK: begin
					if (!any_strobe) begin
						ok    <= 1'b0; // falls the cycle after the release.
						armed <= 1'b1;
						op    <= mem_bus_pkg::OP_NONE;
						state <= mem_bus_pkg::S_IDLE;
					end
				end

				default: state <= mem_bus_pkg::S_IDLE;
			endcase
		end
	end

	// ====================
	// cycle payload
	// ====================

	// the address and data are stable while the strobe is held, so they are taken once.
	always_ff @(posedge clk) begin
		if (start) begin
			page             <= {seg,
				addr[mem_bus_pkg::ADDR_W-1 -: mem_map_pkg::PAGE_W - mem_bus_pkg::SEG_W]};
			req_if.offset    <= addr[mem_map_pkg::OFFSET_W-1:0];
			req_if.wdata     <= wdata;
			req_if.write     <= (next_op == mem_bus_pkg::OP_WRITE);
			cfg_page         <= wdata[mem_map_pkg::PAGE_W-1:0]; // page to configure.
			cfg_entry.valid  <= addr[0];
			cfg_entry.frame  <= addr[3:1];
			cfg_entry.mod_id <= addr[5:4];
		end
		if (state == mem_bus_pkg::S_ACCESS)
			req_if.frame <= entry.frame; // goes out together with the request.
	end

endmodule

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

	// ====================
	// bus geometry
	// ====================

	localparam int DATA_W = 16; // data word width.
	localparam int ADDR_W = 16; // address width of one bus cycle.
	localparam int SEG_W  = 4;  // segment number width, the high part of the page.

	// ====================
	// bus operations
	// ====================

	// the operation latched by the sequencer when a strobe is first seen.
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2,
		OP_CFG   = 2'd3
	} bus_op_e;

	// ====================
	// sequencer states
	// ====================

	// one bus cycle walks through these states in order.
	// configure cycles skip S_ACCESS, unmapped pages leave from S_ACCESS.
	typedef enum logic [2:0] {
		S_IDLE   = 3'd0, // waiting for a strobe while armed.
		S_MAP    = 3'd1, // map lookup or map write in flight.
		S_ACCESS = 3'd2, // entry is valid to check, request goes out.
		S_WAIT   = 3'd3, // waiting for the module or the map.
		S_OK     = 3'd4  // ok is held until the strobe drops.
	} seq_state_e;

endpackage

//--- design/mem_map_pkg.sv
package mem_map_pkg;

	// ====================
	// map geometry
	// ====================

	localparam int NUM_MODULES = 4;
	localparam int MOD_W       = 2; // selects one of NUM_MODULES.
	localparam int FRAMES      = 8; // frames held by one module.
	localparam int FRAME_W     = 3;
	localparam int PAGE_W      = 8; // segment number and the upper address bits.
	localparam int OFFSET_W    = 12; // a frame holds 2**OFFSET_W words.
	localparam int MAP_DEPTH   = 2 ** PAGE_W;

	// one page map entry.
	// an entry with valid low leaves the page unmapped and the access gets no ok.
	typedef struct packed {
		logic               valid;
		logic [MOD_W-1:0]   mod_id;
		logic [FRAME_W-1:0] frame;
	} map_entry_t;

endpackage

//--- design/mem_module.sv
`timescale 1ns/1ns

module mem_module (
	input  logic                           clk,
	mem_req_if.slave                       req_if,
	input  logic                           sel,
	output logic                           rvalid,
	output logic [mem_bus_pkg::DATA_W-1:0] rdata
);

	localparam int WORDS = mem_map_pkg::FRAMES * 2 ** mem_map_pkg::OFFSET_W;

	// the eight frames lie end to end and the frame number is the top of the word address.
	logic [mem_bus_pkg::DATA_W-1:0] mem [WORDS];

	logic [mem_map_pkg::FRAME_W+mem_map_pkg::OFFSET_W-1:0] word_addr;
	logic hit;

	assign word_addr = {req_if.frame, req_if.offset};
	assign hit       = req_if.req & sel; // the request is shared, sel picks this module.

	// ====================
	// storage access
	// ====================

	always_ff @(posedge clk) begin
		if (hit && req_if.write)
			mem[word_addr] <= req_if.wdata;
	end

	// read data comes back one cycle after the request, flagged by rvalid.
	always_ff @(posedge clk) begin
		rvalid <= hit & ~req_if.write;
		if (hit && !req_if.write)
			rdata <= mem[word_addr];
	end

endmodule

//--- design/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if;

	logic                             req;    // one cycle pulse per access.
	logic                             write;  // high for a write, low for a read.
	logic [mem_map_pkg::FRAME_W-1:0]  frame;  // physical frame inside the module.
	logic [mem_map_pkg::OFFSET_W-1:0] offset; // word inside the frame.
	logic [mem_bus_pkg::DATA_W-1:0]   wdata;

	// the sequencer drives every request field.
	modport master (
		output req, write, frame, offset, wdata
	);

	// all modules share the same request and qualify it with their own sel bit.
	modport slave (
		input req, write, frame, offset, wdata
	);

endinterface

//--- design/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           rd,
	input  logic                           wr,
	input  logic                           cfg,
	input  logic [mem_bus_pkg::SEG_W-1:0]  seg,
	input  logic [mem_bus_pkg::ADDR_W-1:0] addr,
	input  logic [mem_bus_pkg::DATA_W-1:0] wdata,
	output logic [mem_bus_pkg::DATA_W-1:0] rdata,
	output logic                           ok
);

	// map lookup and configure path.
	logic                           lookup_en;
	logic [mem_map_pkg::PAGE_W-1:0] page;
	logic                           cfg_we;
	logic [mem_map_pkg::PAGE_W-1:0] cfg_page;
	mem_map_pkg::map_entry_t        cfg_entry;
	mem_map_pkg::map_entry_t        entry;

	// module select and read return path.
	logic [mem_map_pkg::NUM_MODULES-1:0]                          sel;
	logic [mem_map_pkg::NUM_MODULES-1:0]                          mod_rvalid;
	logic [mem_map_pkg::NUM_MODULES-1:0][mem_bus_pkg::DATA_W-1:0] mod_rdata;
	logic                                                         done;

	mem_req_if req_bus ();

	page_map u_page_map (
		.clk       (clk),
		.rst_n     (rst_n),
		.lookup_en (lookup_en),
		.page      (page),
		.cfg_we    (cfg_we),
		.cfg_page  (cfg_page),
		.cfg_entry (cfg_entry),
		.entry     (entry)
	);

	bus_sequencer u_bus_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd        (rd),
		.wr        (wr),
		.cfg       (cfg),
		.seg       (seg),
		.addr      (addr),
		.wdata     (wdata),
		.lookup_en (lookup_en),
		.page      (page),
		.cfg_we    (cfg_we),
		.cfg_page  (cfg_page),
		.cfg_entry (cfg_entry),
		.entry     (entry),
		.req_if    (req_bus.master),
		.sel       (sel),
		.done      (done),
		.ok        (ok)
	);

	// ====================
	// memory modules
	// ====================

	for (genvar g = 0; g < mem_map_pkg::NUM_MODULES; g++) begin : g_mod
		mem_module u_mem_module (
			.clk    (clk),
			.req_if (req_bus.slave),
			.sel    (sel[g]),
			.rvalid (mod_rvalid[g]),
			.rdata  (mod_rdata[g])
		);
	end

	read_collector u_read_collector (
		.clk      (clk),
		.rst_n    (rst_n),
		.rvalid   (mod_rvalid),
		.rdata_in (mod_rdata),
		.done     (done),
		.rdata    (rdata)
	);

endmodule

//--- design/page_map.sv
`timescale 1ns/1ns

module page_map (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            lookup_en,
	input  logic [mem_map_pkg::PAGE_W-1:0]  page,
	input  logic                            cfg_we,
	input  logic [mem_map_pkg::PAGE_W-1:0]  cfg_page,
	input  mem_map_pkg::map_entry_t         cfg_entry,
	output mem_map_pkg::map_entry_t         entry
);

	// ====================
	// table storage
	// ====================

	// the valid bits live in a flat vector so that reset can clear all of them at once.
	logic [mem_map_pkg::MAP_DEPTH-1:0] valid_q;

	// the translation fields are plain storage.
	logic [mem_map_pkg::MOD_W-1:0]   mod_mem   [mem_map_pkg::MAP_DEPTH];
	logic [mem_map_pkg::FRAME_W-1:0] frame_mem [mem_map_pkg::MAP_DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0; // every page starts unmapped.
		end else if (cfg_we) begin
			valid_q[cfg_page] <= cfg_entry.valid;
		end
	end

	// a configure cycle rewrites the fields even when it unmaps the page.
	always_ff @(posedge clk) begin
		if (cfg_we) begin
			mod_mem[cfg_page]   <= cfg_entry.mod_id;
			frame_mem[cfg_page] <= cfg_entry.frame;
		end
	end

	// ====================
	// registered lookup
	// ====================

	// the entry shows up one cycle after lookup_en and holds until the next lookup.
	// a configure write in the same cycle wins and the lookup is not performed.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			entry <= '0;
		end else if (!cfg_we && lookup_en) begin
			entry.valid  <= valid_q[page];
			entry.mod_id <= mod_mem[page];
			entry.frame  <= frame_mem[page];
		end
	end

endmodule

//--- design/read_collector.sv
`timescale 1ns/1ns

module read_collector (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic [mem_map_pkg::NUM_MODULES-1:0]                    rvalid,
	input  logic [mem_map_pkg::NUM_MODULES-1:0][mem_bus_pkg::DATA_W-1:0] rdata_in,
	output logic                                                   done,
	output logic [mem_bus_pkg::DATA_W-1:0]                         rdata
);

	logic [mem_bus_pkg::DATA_W-1:0] pick;

	// at most one module answers a read, since sel is one-hot.
	always_comb begin
		pick = '0;
		for (int i = 0; i < mem_map_pkg::NUM_MODULES; i++) begin
			if (rvalid[i])
				pick = rdata_in[i];
		end
	end

	// ====================
	// result register
	// ====================

	// rdata is only replaced by the next read.
	// it stays stable for the whole time ok is held.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done  <= 1'b0;
			rdata <= '0;
		end else begin
			done <= |rvalid; // one cycle pulse to the sequencer.
			if (|rvalid)
				rdata <= pick;
		end
	end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 5; // 10 ns clock period.
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset drops 1 ns after an edge, the same way the bus inputs change.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

	localparam int OK_LIMIT    = 20; // a mapped access that takes longer is lost.
	localparam int NO_OK_WAIT  = 10; // how long an unmapped access is watched.
	localparam int RESET_LIMIT = 40;
	localparam int READ_LAT    = 5;
	localparam int WRITE_LAT   = 3;
	localparam int CFG_LAT     = 2;

	logic                           clk;
	logic                           rst_n;
	logic                           rd;
	logic                           wr;
	logic                           cfg;
	logic [mem_bus_pkg::SEG_W-1:0]  seg;
	logic [mem_bus_pkg::ADDR_W-1:0] addr;
	logic [mem_bus_pkg::DATA_W-1:0] wdata;
	logic [mem_bus_pkg::DATA_W-1:0] rdata;
	logic                           ok;

	// the reference model is a page map and a sparse store keyed by module, frame and offset.
	mem_map_pkg::map_entry_t        map_model [mem_map_pkg::MAP_DEPTH];
	logic [mem_bus_pkg::DATA_W-1:0] mem_model [int];

	logic [19:0] written [$]; // {page, offset} of every write that got ok.
	logic [7:0]  pages [$];   // pages mapped during the run.

	logic [31:0] lcg_state = 32'hc6d61366;
	int          mismatch_errs = 0;
	int          protocol_errs = 0;

	tb_clock_gen clk_gen0 (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mem_subsystem dut0 (
		.clk   (clk),
		.rst_n (rst_n),
		.rd    (rd),
		.wr    (wr),
		.cfg   (cfg),
		.seg   (seg),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.ok    (ok)
	);

	// ====================
	// helpers
	// ====================

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// the low bits of the generator repeat quickly, so the upper ones are used.
	function automatic int rand_below(input int n);
		return int'(rand_next() >> 8) % n;
	endfunction

	function automatic int phys_key(input logic [7:0] page, input logic [11:0] offset);
		mem_map_pkg::map_entry_t e;
		e = map_model[page];
		return int'({e.mod_id, e.frame, offset});
	endfunction

	// one full bus cycle. entered and left 1 ns after a rising edge.
	task automatic run_cycle(input mem_bus_pkg::bus_op_e op, input logic [3:0] s,
			input logic [15:0] a, input logic [15:0] d, input int limit, input int hold,
			output logic got_ok, output int lat, output logic [15:0] data);
		int n;
		int i;
		seg    = s;
		addr   = a;
		wdata  = d;
		rd     = (op == mem_bus_pkg::OP_READ);
		wr     = (op == mem_bus_pkg::OP_WRITE);
		cfg    = (op == mem_bus_pkg::OP_CFG);
		got_ok = 1'b0;
		n      = 0;
		while (!got_ok && n < limit) begin
			@(posedge clk);
			#1;
			n++;
			got_ok = ok;
		end
		lat  = n - 1; // edges after the one that first saw the strobe.
		data = rdata;
		for (i = 0; i < hold && got_ok; i++) begin
			@(posedge clk);
			#1;
			assert (ok === 1'b1) else begin
				protocol_errs++;
				$display("ok dropped while the strobe was still held");
			end
			assert (rdata === data) else begin
				mismatch_errs++;
				$display("mismatch at %0t ns: rdata moved to %h while ok held %h",
					$time, rdata, data);
			end
		end
		rd  = 1'b0;
		wr  = 1'b0;
		cfg = 1'b0;
		@(posedge clk);
		#1;
		assert (ok === 1'b0) else begin
			protocol_errs++;
			$display("ok stayed high after the strobe was released");
		end
	endtask

	task automatic configure(input logic [7:0] page, input logic valid,
			input logic [1:0] mod_id, input logic [2:0] frame);
		logic        got_ok;
		int          lat;
		logic [15:0] data;
		run_cycle(mem_bus_pkg::OP_CFG, 4'(rand_next() >> 8),
			{10'(rand_next() >> 8), mod_id, frame, valid}, {8'(rand_next() >> 8), page},
			OK_LIMIT, 0, got_ok, lat, data);
		map_model[page].valid  = valid; // the map is written whether or not ok shows.
		map_model[page].mod_id = mod_id;
		map_model[page].frame  = frame;
		assert (got_ok) else begin
			protocol_errs++;
			$display("ok never rose for configure of page %h", page);
		end
		if (got_ok) begin
			assert (lat == CFG_LAT) else begin
				mismatch_errs++;
				$display("mismatch at %0t ns: configure ok after %0d cycles, expected %0d",
					$time, lat, CFG_LAT);
			end
		end
	endtask

	task automatic access(input mem_bus_pkg::bus_op_e op, input logic [7:0] page,
			input logic [11:0] offset, input int hold);
		logic [15:0] d;
		logic [15:0] data;
		logic        got_ok;
		logic        mapped;
		int          lat;
		int          exp_lat;
		int          key;
		d       = 16'(rand_next() >> 8);
		mapped  = map_model[page].valid;
		key     = phys_key(page, offset);
		exp_lat = (op == mem_bus_pkg::OP_READ) ? READ_LAT : WRITE_LAT;
		run_cycle(op, page[7:4], {page[3:0], offset}, d, mapped ? OK_LIMIT : NO_OK_WAIT,
			hold, got_ok, lat, data);
		if (!mapped) begin
			assert (!got_ok) else begin
				protocol_errs++;
				$display("ok rose for an access to unmapped page %h", page);
			end
		end else begin
			assert (got_ok) else begin
				protocol_errs++;
				$display("ok never rose for %s",
					(op == mem_bus_pkg::OP_READ) ? "read" : "write");
			end
			if (got_ok) begin
				assert (lat == exp_lat) else begin
					mismatch_errs++;
					$display("mismatch at %0t ns: ok after %0d cycles, expected %0d",
						$time, lat, exp_lat);
				end
				if (op == mem_bus_pkg::OP_WRITE) begin
					mem_model[key] = d;
					written.push_back({page, offset});
				end else if (mem_model.exists(key)) begin
					assert (data === mem_model[key]) else begin
						mismatch_errs++;
						$display("mismatch at %0t ns: page %h offset %h read %h, expected %h",
							$time, page, offset, data, mem_model[key]);
					end
				end
			end
		end
	endtask

	// ====================
	// test sequence
	// ====================

	initial begin
		int          n;
		int          i;
		logic [7:0]  pg;
		logic [7:0]  pg_b;
		logic [11:0] off;
		logic [19:0] loc;
		rd    = 1'b0;
		wr    = 1'b0;
		cfg   = 1'b0;
		seg   = '0;
		addr  = '0;
		wdata = '0;
		foreach (map_model[k])
			map_model[k] = '0;

		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (rst_n !== 1'b1 && n < RESET_LIMIT);
		#1;
		assert (rst_n === 1'b1) else begin
			protocol_errs++;
			$display("reset was never released");
		end

		if (rst_n === 1'b1) begin
			// nothing is mapped yet, so no read may be answered.
			for (i = 0; i < 4; i++)
				access(mem_bus_pkg::OP_READ, 8'(rand_below(256)), 12'(rand_below(4096)), 0);

			for (i = 0; i < 8; i++) begin
				pg = 8'(rand_below(256));
				configure(pg, 1'b1, 2'(rand_below(4)), 3'(rand_below(8)));
				pages.push_back(pg);
			end

			for (i = 0; i < 40; i++)
				access(mem_bus_pkg::OP_WRITE, pages[rand_below(pages.size())],
					12'(rand_below(4096)), 0);
			for (i = 0; i < 40; i++) begin
				loc = written[rand_below(written.size())];
				access(mem_bus_pkg::OP_READ, loc[19:12], loc[11:0], 0);
			end

			// two pages on one physical frame.
			pg   = 8'(rand_below(256));
			pg_b = pg + 8'(1 + rand_below(255));
			configure(pg, 1'b1, 2'(rand_below(4)), 3'(rand_below(8)));
			configure(pg_b, 1'b1, map_model[pg].mod_id, map_model[pg].frame);
			for (i = 0; i < 6; i++) begin
				off = 12'(rand_below(4096));
				access(mem_bus_pkg::OP_WRITE, pg, off, 0);
				access(mem_bus_pkg::OP_READ, pg_b, off, 0);
			end
			pages.push_back(pg);
			pages.push_back(pg_b);

			configure(pages[0], 1'b0, 2'(rand_below(4)), 3'(rand_below(8)));
			access(mem_bus_pkg::OP_READ, pages[0], 12'(rand_below(4096)), 0);
			access(mem_bus_pkg::OP_WRITE, pages[0], 12'(rand_below(4096)), 0);
			foreach (written[j])
				access(mem_bus_pkg::OP_READ, written[j][19:12], written[j][11:0], 0);

			// the master keeps the strobe up a few cycles past ok.
			for (i = 0; i < 12; i++) begin
				loc = written[rand_below(written.size())];
				access(mem_bus_pkg::OP_READ, loc[19:12], loc[11:0], 1 + rand_below(6));
			end
		end

		$display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
		if (mismatch_errs + protocol_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
